// File: design/stk_bank_top.sv
/* Storage bank top, line allocator plus one data word per line.
   Alloc/free go to the allocator; writes and reads address the data store by line id. */

`include "stk_defines.svh"

module stk_bank_top (
  // Clock and reset
    input  logic                clk
  , input  logic                i_rst
  // Init
  , input  logic                i_init
  , output logic                o_busy_r
  // Allocator
  , input  logic                i_alloc
  , input  logic                i_free
  , input  stk_pkg::line_id_t   i_free_line
  , output stk_pkg::alloc_rsp_t o_alloc_rsp_r
  , output stk_pkg::cnt_t       o_free_cnt_r
  // Data store
  , input  logic                i_wr
  , input  stk_pkg::wr_req_t    i_wr_req
  , input  logic                i_rd
  , input  stk_pkg::line_id_t   i_rd_line
  , output stk_pkg::rd_rsp_t    o_rd_rsp_r
);

  import stk_pkg::*;

  logic  rd_vld_r;
  word_t rd_data;

  stk_pipe_al u_al (
      .clk           (clk)
    , .i_rst         (i_rst)
    , .i_init        (i_init)
    , .i_alloc       (i_alloc)
    , .i_free        (i_free)
    , .i_free_line   (i_free_line)
    , .o_busy_r      (o_busy_r)
    , .o_alloc_rsp_r (o_alloc_rsp_r)
    , .o_free_cnt_r  (o_free_cnt_r)
  );

  // Line data store, read-old on a same-line collision
  stk_ram_1r1w #(
      .T     (word_t)
    , .DEPTH (`STK_BANK_LINES_N)
  ) u_data (
      .clk     (clk)
    , .i_wen   (i_wr)
    , .i_waddr (i_wr_req.line)
    , .i_wdata (i_wr_req.data)
    , .i_raddr (i_rd_line)
    , .o_rdata (rd_data)
  );

  // Read valid lines up with the registered read data
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rd_vld_r <= 1'b0;
    end else begin
      rd_vld_r <= i_rd;
    end
  end

  always_comb begin
    o_rd_rsp_r.vld  = rd_vld_r;
    o_rd_rsp_r.data = rd_data;
  end

endmodule : stk_bank_top

// File: design/stk_defines.svh
/* Bank sizing macros for the stack engine storage bank.
   Include wherever line count, id width or word width is needed. */

`ifndef STK_DEFINES_SVH
`define STK_DEFINES_SVH

// Lines per bank, must be a power of two
// Also sets the depth of the free list
`define STK_BANK_LINES_N 16

// Line id width, log2 of the line count
`define STK_LINE_ID_W $clog2(`STK_BANK_LINES_N)

// Data word width in the line store
`define STK_WORD_W 32

`endif

// File: design/stk_pipe_al.sv
/* Line allocator, a circular queue of free line ids held in a 1R1W free list.
   Pops ids on alloc strobes, pushes ids on free strobes, refilled by the init sequencer. */

`include "stk_defines.svh"

module stk_pipe_al (
  // Clock and reset
    input  logic                clk
  , input  logic                i_rst
  // Control
  , input  logic                i_init
  // Alloc and free
  , input  logic                i_alloc
  , input  logic                i_free
  , input  stk_pkg::line_id_t   i_free_line
  // Status and responses
  , output logic                o_busy_r
  , output stk_pkg::alloc_rsp_t o_alloc_rsp_r
  , output stk_pkg::cnt_t       o_free_cnt_r
);

  import stk_pkg::*;

  localparam cnt_t LINES_N = cnt_t'(`STK_BANK_LINES_N);

  // Init sequencer side
  logic     init_wen;
  line_id_t init_waddr;
  line_id_t init_wdata;
  logic     busy;
  logic     busy_q;
  logic     busy_fall;

  // Queue state
  line_id_t head_r;
  line_id_t tail_r;
  logic     alloc_ok;
  logic     free_ok;

  // Free-list ports
  logic     fl_wen;
  line_id_t fl_waddr;
  line_id_t fl_wdata;
  line_id_t fl_rdata;

  // Response pulses
  logic     rsp_vld_r;
  logic     rsp_fail_r;

  stk_pipe_al_init u_init (
      .o_init_wen_r   (init_wen)
    , .o_init_waddr_r (init_waddr)
    , .o_init_wdata_r (init_wdata)
    , .i_init         (i_init)
    , .o_busy_r       (busy)
    , .clk            (clk)
    , .i_rst          (i_rst)
  );

  // Falling edge of busy marks end of init
  always_ff @(posedge clk) begin
    if (i_rst) begin
      busy_q <= 1'b0;
    end else begin
      busy_q <= busy;
    end
  end

  assign busy_fall = busy_q & ~busy;

  // Request qualification
  // During init the count is held at zero, so the cycle after busy falls
  // still refuses allocs; frees there are dropped since the bank is about to be full
  assign alloc_ok = i_alloc & ~busy & (o_free_cnt_r != '0);
  assign free_ok  = i_free & ~busy & ~busy_fall & (o_free_cnt_r != LINES_N);

  // Write port arbitration, init owns the port while busy
  assign fl_wen   = busy ? init_wen   : free_ok;
  assign fl_waddr = busy ? init_waddr : tail_r;
  assign fl_wdata = busy ? init_wdata : i_free_line;

  // Free list, read port parked on the head
  stk_ram_1r1w #(
      .T     (line_id_t)
    , .DEPTH (`STK_BANK_LINES_N)
  ) u_free_list (
      .clk     (clk)
    , .i_wen   (fl_wen)
    , .i_waddr (fl_waddr)
    , .i_wdata (fl_wdata)
    , .i_raddr (head_r)
    , .o_rdata (fl_rdata)
  );

  // Head, tail and free count
  // Pointers wrap naturally, line count is a power of two
  always_ff @(posedge clk) begin
    if (i_rst) begin
      head_r       <= '0;
      tail_r       <= '0;
      o_free_cnt_r <= '0;
    end else if (busy) begin
      // Nothing allocatable until init finishes
      o_free_cnt_r <= '0;
    end else if (busy_fall) begin
      // Every id now sits in the queue, from address 0
      head_r       <= '0;
      tail_r       <= '0;
      o_free_cnt_r <= LINES_N;
    end else begin
      if (alloc_ok) begin
        head_r <= head_r + 1'b1;
      end
      if (free_ok) begin
        tail_r <= tail_r + 1'b1;
      end
      // Simultaneous pop and push leave the count as is
      case ({alloc_ok, free_ok})
        2'b10:   o_free_cnt_r <= o_free_cnt_r - 1'b1;
        2'b01:   o_free_cnt_r <= o_free_cnt_r + 1'b1;
        default: o_free_cnt_r <= o_free_cnt_r;
      endcase
    end
  end

  // Response flags, one cycle per strobe
  always_ff @(posedge clk) begin
    if (i_rst) begin
      rsp_vld_r  <= 1'b0;
      rsp_fail_r <= 1'b0;
    end else begin
      rsp_vld_r  <= alloc_ok;
      rsp_fail_r <= i_alloc & ~alloc_ok;
    end
  end

  // Id comes from the registered head read, captured on the same edge as the flags
  always_comb begin
    o_alloc_rsp_r.vld  = rsp_vld_r;
    o_alloc_rsp_r.fail = rsp_fail_r;
    o_alloc_rsp_r.line = rsp_vld_r ? fl_rdata : '0;
  end

  assign o_busy_r = busy;

endmodule : stk_pipe_al

// File: design/stk_pipe_al_init.sv
/* Free-list init sequencer, writes each line id to its own address after a start pulse.
   Busy stays high for the whole sequence and the allocator steers the write port on it. */

`include "stk_defines.svh"

module stk_pipe_al_init (
  // Free-list write port
    output logic              o_init_wen_r
  , output stk_pkg::line_id_t o_init_waddr_r
  , output stk_pkg::line_id_t o_init_wdata_r
  // Control and status
  , input  logic              i_init
  , output logic              o_busy_r
  // Clock and reset
  , input  logic              clk
  , input  logic              i_rst
);

  import stk_pkg::*;

  // One-hot states, EXIT is all zeros and is the reset state
  typedef enum logic [2:0] {
    ST_EXIT = 3'b000,
    // Single cycle to clear the address counter
    ST_IDLE = 3'b001,
    // One id written per cycle
    ST_BUSY = 3'b010,
    // Last cycle with busy held high
    ST_DONE = 3'b100
  } state_t;

  localparam line_id_t LAST_ADDR = line_id_t'(`STK_BANK_LINES_N - 1);

  state_t state_r;
  state_t state_nxt;
  logic   st_idle;
  logic   st_busy;
  logic   addr_last;

  // State decode
  assign st_idle   = (state_r == ST_IDLE);
  assign st_busy   = (state_r == ST_BUSY);
  assign addr_last = (o_init_waddr_r == LAST_ADDR);

  // Next state
  always_comb begin
    state_nxt = state_r;
    case (state_r)
      ST_IDLE: begin
        state_nxt = ST_BUSY;
      end
      ST_BUSY: begin
        // Hold until the final line has been written
        if (addr_last) begin
          state_nxt = ST_DONE;
        end
      end
      ST_DONE: begin
        state_nxt = ST_EXIT;
      end
      default: begin
        // EXIT and any illegal code park here
        state_nxt = ST_EXIT;
      end
    endcase
    // Start pulse wins from any state, so a new init restarts the sequence
    if (i_init) begin
      state_nxt = ST_IDLE;
    end
  end

  // State plus status flops
  // Busy and write enable come from next state, so both are clean flop outputs
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_r      <= ST_EXIT;
      o_busy_r     <= 1'b0;
      o_init_wen_r <= 1'b0;
    end else begin
      state_r      <= state_nxt;
      o_busy_r     <= (state_nxt != ST_EXIT);
      o_init_wen_r <= (state_nxt == ST_BUSY);
    end
  end

  // Address counter
  // Zeroed in IDLE, steps once per BUSY cycle, frozen otherwise
  always_ff @(posedge clk) begin
    if (st_idle) begin
      o_init_waddr_r <= '0;
    end else if (st_busy) begin
      o_init_waddr_r <= o_init_waddr_r + 1'b1;
    end
  end

  // Id written equals its address, queue comes out in ascending order
  assign o_init_wdata_r = o_init_waddr_r;

endmodule : stk_pipe_al_init

// File: design/stk_pkg.sv
/* Shared types of the storage bank: ids, counts, words and the request/response structs.
   Compile first; modules import it in their bodies and use scoped names in port lists. */

`include "stk_defines.svh"

package stk_pkg;

  // Line id, indexes both the free list and the data store
  typedef logic [`STK_LINE_ID_W-1:0] line_id_t;

  // Free count, one extra bit so a full bank of N fits
  typedef logic [`STK_LINE_ID_W:0] cnt_t;

  // Payload word kept per line
  typedef logic [`STK_WORD_W-1:0] word_t;

  // Allocator answer, one-cycle pulse
  // vld and fail are mutually exclusive
  typedef struct packed {
    logic     vld;
    logic     fail;
    line_id_t line;
  } alloc_rsp_t;

  // Data store write
  typedef struct packed {
    line_id_t line;
    word_t    data;
  } wr_req_t;

  // Data store read return
  // vld one cycle after the read strobe
  typedef struct packed {
    logic  vld;
    word_t data;
  } rd_rsp_t;

endpackage : stk_pkg

// File: design/stk_ram_1r1w.sv
/* Simple dual-port storage, one write port and one registered read port.
   Payload type is a parameter; used for the free list and for the line data store. */

`include "stk_defines.svh"

module stk_ram_1r1w #(
    parameter type         T     = stk_pkg::word_t
  , parameter int unsigned DEPTH = `STK_BANK_LINES_N
) (
  // Clock
    input  logic              clk
  // Write port
  , input  logic              i_wen
  , input  stk_pkg::line_id_t i_waddr
  , input  T                  i_wdata
  // Read port
  , input  stk_pkg::line_id_t i_raddr
  , output T                  o_rdata
);

  // Storage array, no reset on contents
  T mem_q [DEPTH];

  // Write
  always_ff @(posedge clk) begin
    if (i_wen) begin
      mem_q[i_waddr] <= i_wdata;
    end
  end

  // Registered read, every cycle
  // Same-address write in the same cycle returns the old entry
  always_ff @(posedge clk) begin
    o_rdata <= mem_q[i_raddr];
  end

endmodule : stk_ram_1r1w

// File: sim.f
+incdir+design
design/stk_pkg.sv
design/stk_ram_1r1w.sv
design/stk_pipe_al_init.sv
design/stk_pipe_al.sv
design/stk_bank_top.sv
verif/stk_props.sv
verif/stk_tb.sv

// File: verif/stk_props.sv
/* Concurrent assertions on the allocator that are bound into every stk_pipe_al instance.
   Compiled with the testbench sources and needs no manual instantiation. */

`include "stk_defines.svh"

module stk_props (
    input logic                clk
  , input logic                i_rst
  , input stk_pkg::cnt_t       i_free_cnt
  , input stk_pkg::alloc_rsp_t i_alloc_rsp
  , input logic                i_init_wen
  , input logic                i_busy
);

  timeunit 1ns;
  timeprecision 100ps;

  import stk_pkg::*;

  localparam cnt_t LINES_N = cnt_t'(`STK_BANK_LINES_N);

  // Number of assertion failures so far
  int unsigned n_fail = 0;

  // Queue can never hold more ids than the bank has lines
  a_cnt_max: assert property (@(posedge clk) disable iff (i_rst)
    i_free_cnt <= LINES_N)
    else begin
      n_fail++;
      $error("free count above line count");
    end

  // One answer per alloc strobe
  a_rsp_excl: assert property (@(posedge clk) disable iff (i_rst)
    !(i_alloc_rsp.vld && i_alloc_rsp.fail))
    else begin
      n_fail++;
      $error("alloc response has vld and fail together");
    end

  // Init writes stay inside the busy window
  a_wen_busy: assert property (@(posedge clk) disable iff (i_rst)
    i_init_wen |-> i_busy)
    else begin
      n_fail++;
      $error("init write enable outside busy");
    end

endmodule : stk_props

bind stk_pipe_al stk_props u_props (
    .clk         (clk)
  , .i_rst       (i_rst)
  , .i_free_cnt  (o_free_cnt_r)
  , .i_alloc_rsp (o_alloc_rsp_r)
  , .i_init_wen  (init_wen)
  , .i_busy      (busy)
);

// File: verif/stk_tb.sv
/* Directed testbench for the storage bank with a queue model of the free list and a word model.
   Run from the file list with stk_tb as top; allocator assertions are bound in separately. */

`include "stk_defines.svh"

module stk_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import stk_pkg::*;

  localparam int N           = `STK_BANK_LINES_N;
  localparam int WDOG_CYCLES = 4 * N + 200;

  logic       clk;
  logic       i_rst;
  logic       i_init;
  logic       i_alloc;
  logic       i_free;
  line_id_t   i_free_line;
  logic       i_wr;
  wr_req_t    i_wr_req;
  logic       i_rd;
  line_id_t   i_rd_line;
  logic       o_busy_r;
  alloc_rsp_t o_alloc_rsp_r;
  cnt_t       o_free_cnt_r;
  rd_rsp_t    o_rd_rsp_r;

  // Reference state
  line_id_t fl_model [$];
  word_t    mem_model [N];
  integer   seed = 27;
  int       n_errors;
  int       n_checks;

  stk_bank_top dut_i (
      .clk           (clk)
    , .i_rst         (i_rst)
    , .i_init        (i_init)
    , .o_busy_r      (o_busy_r)
    , .i_alloc       (i_alloc)
    , .i_free        (i_free)
    , .i_free_line   (i_free_line)
    , .o_alloc_rsp_r (o_alloc_rsp_r)
    , .o_free_cnt_r  (o_free_cnt_r)
    , .i_wr          (i_wr)
    , .i_wr_req      (i_wr_req)
    , .i_rd          (i_rd)
    , .i_rd_line     (i_rd_line)
    , .o_rd_rsp_r    (o_rd_rsp_r)
  );

  // 40 ns clock
  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Run bound to the expected test length
  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

  // Inputs change and outputs are sampled 2 ns after the edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("ERR %s got %0h expected %0h at %0t", name, got, exp, $time);
    end
  endtask

  // One cycle of alloc and free checked against the queue model
  task automatic alloc_free_cycle(input logic alloc, input logic free, input line_id_t fline);
    logic     exp_vld;
    logic     free_take;
    line_id_t exp_line;
    // Count before this cycle decides both requests
    exp_vld   = alloc && (fl_model.size() != 0);
    free_take = free && (fl_model.size() != N);
    exp_line  = exp_vld ? fl_model[0] : '0;
    i_alloc     = alloc;
    i_free      = free;
    i_free_line = fline;
    next_cycle();
    i_alloc = 1'b0;
    i_free  = 1'b0;
    if (exp_vld)
      void'(fl_model.pop_front());
    if (free_take)
      fl_model.push_back(fline);
    check_val("alloc_rsp.vld", o_alloc_rsp_r.vld, exp_vld);
    check_val("alloc_rsp.fail", o_alloc_rsp_r.fail, alloc && !exp_vld);
    check_val("alloc_rsp.line", o_alloc_rsp_r.line, exp_line);
    check_val("free_cnt", o_free_cnt_r, fl_model.size());
  endtask

  // Init pulse with the busy window length and an alloc refused while busy
  task automatic run_init();
    int n_high;
    i_init = 1'b1;
    next_cycle();
    i_init = 1'b0;
    n_high = 0;
    while (o_busy_r === 1'b1 && n_high < N + 8) begin
      n_high++;
      i_alloc = (n_high == 2);
      next_cycle();
      i_alloc = 1'b0;
      if (n_high == 2) begin
        check_val("alloc_rsp.fail", o_alloc_rsp_r.fail, 1'b1);
        check_val("alloc_rsp.vld", o_alloc_rsp_r.vld, 1'b0);
      end
    end
    check_val("busy_cycles", n_high, N + 2);
    check_val("free_cnt", o_free_cnt_r, 0);
    // Count loads one cycle after busy drops
    next_cycle();
    check_val("busy", o_busy_r, 1'b0);
    check_val("free_cnt", o_free_cnt_r, N);
    fl_model.delete();
    for (int i = 0; i < N; i++)
      fl_model.push_back(line_id_t'(i));
  endtask

  task automatic write_word(input line_id_t ln, input word_t w);
    i_wr          = 1'b1;
    i_wr_req.line = ln;
    i_wr_req.data = w;
    next_cycle();
    i_wr = 1'b0;
    mem_model[ln] = w;
    check_val("rd_rsp.vld", o_rd_rsp_r.vld, 1'b0);
  endtask

  task automatic read_word(input line_id_t ln);
    i_rd      = 1'b1;
    i_rd_line = ln;
    next_cycle();
    i_rd = 1'b0;
    check_val("rd_rsp.vld", o_rd_rsp_r.vld, 1'b1);
    check_val("rd_rsp.data", o_rd_rsp_r.data, mem_model[ln]);
  endtask

  // Nothing allocatable before the first init
  task automatic reset_state_check();
    check_val("busy", o_busy_r, 1'b0);
    check_val("free_cnt", o_free_cnt_r, 0);
    check_val("rd_rsp.vld", o_rd_rsp_r.vld, 1'b0);
    alloc_free_cycle(1'b1, 1'b0, '0);
  endtask

  // Ids come out 0 to N-1 and then the empty list refuses
  task automatic drain_free_list();
    for (int i = 0; i < N; i++)
      alloc_free_cycle(1'b1, 1'b0, '0);
    alloc_free_cycle(1'b1, 1'b0, '0);
  endtask

  task automatic free_random_order();
    line_id_t perm [N];
    line_id_t tmp;
    int       j;
    for (int i = 0; i < N; i++)
      perm[i] = line_id_t'(i);
    for (int i = N - 1; i > 0; i--) begin
      j       = $unsigned($random(seed)) % (i + 1);
      tmp     = perm[i];
      perm[i] = perm[j];
      perm[j] = tmp;
    end
    // On an empty list the id freed this cycle is not handed out yet
    alloc_free_cycle(1'b1, 1'b1, perm[0]);
    for (int i = 1; i < N / 2; i++)
      alloc_free_cycle(1'b0, 1'b1, perm[i]);
    // Pop and push together
    for (int i = N / 2; i < N / 2 + 4; i++)
      alloc_free_cycle(1'b1, 1'b1, perm[i]);
    for (int i = N / 2 + 4; i < N; i++)
      alloc_free_cycle(1'b0, 1'b1, perm[i]);
    while (fl_model.size() != 0)
      alloc_free_cycle(1'b1, 1'b0, '0);
  endtask

  task automatic data_store_rw();
    line_id_t ln;
    word_t    w;
    for (int i = 0; i < N; i++)
      write_word(line_id_t'(i), word_t'($random(seed)));
    repeat (8) begin
      ln = line_id_t'($random(seed));
      w  = word_t'($random(seed));
      write_word(ln, w);
    end
    for (int i = 0; i < N; i++)
      read_word(line_id_t'(i));
    // Same-line collision reads the old word
    ln            = line_id_t'($random(seed));
    w             = word_t'($random(seed));
    i_wr          = 1'b1;
    i_wr_req.line = ln;
    i_wr_req.data = w;
    i_rd          = 1'b1;
    i_rd_line     = ln;
    next_cycle();
    i_wr = 1'b0;
    i_rd = 1'b0;
    check_val("rd_rsp.vld", o_rd_rsp_r.vld, 1'b1);
    check_val("rd_rsp.data", o_rd_rsp_r.data, mem_model[ln]);
    mem_model[ln] = w;
    read_word(ln);
  endtask

  // Reinit from a partly used queue
  task automatic init_mid_run();
    alloc_free_cycle(1'b0, 1'b1, line_id_t'(9));
    alloc_free_cycle(1'b0, 1'b1, line_id_t'(4));
    alloc_free_cycle(1'b1, 1'b1, line_id_t'(12));
    run_init();
    // Full list drops the free
    alloc_free_cycle(1'b0, 1'b1, line_id_t'(5));
    for (int i = 0; i < 3; i++)
      alloc_free_cycle(1'b1, 1'b0, '0);
  endtask

  initial begin
    i_rst       = 1'b1;
    i_init      = 1'b0;
    i_alloc     = 1'b0;
    i_free      = 1'b0;
    i_free_line = '0;
    i_wr        = 1'b0;
    i_wr_req    = '0;
    i_rd        = 1'b0;
    i_rd_line   = '0;
    n_errors    = 0;
    n_checks    = 0;
    repeat (10) @(posedge clk);
    #2;
    i_rst = 1'b0;
    reset_state_check();
    run_init();
    drain_free_list();
    free_random_order();
    data_store_rw();
    init_mid_run();
    // Bound allocator assertions add their failures
    n_errors += dut_i.u_al.u_props.n_fail;
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule : stk_tb
